// ==== l1_cache.f ====
hdl/cache_geom_pkg.sv
hdl/cache_fsm_pkg.sv
hdl/l1_controller.sv
hdl/l1_data_array.sv
hdl/l1_cache_top.sv
tb/l2_mem_model.sv
tb/tb_l1_cache.sv

// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - files:
      - hdl/cache_geom_pkg.sv
      - hdl/cache_fsm_pkg.sv
      - hdl/l1_controller.sv
      - hdl/l1_data_array.sv
      - hdl/l1_cache_top.sv
  - target: test
    files:
      - tb/l2_mem_model.sv
      - tb/tb_l1_cache.sv

// ==== tb/tb_l1_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;

    localparam int          CLK_PERIOD   = 100;
    localparam int          NUM_ACCESSES = 18;
    localparam int          ACCESS_LIMIT = 40;
    localparam logic [31:0] SEED         = 32'h29fc97c7;

    typedef struct packed {
        logic                  wr;
        cache_geom_pkg::addr_t addr;
        cache_geom_pkg::word_t wdata;
        logic                  hit;
        logic                  wb;
        cache_geom_pkg::addr_t victim;
    } access_t;

    access_t               tests [NUM_ACCESSES];
    cache_geom_pkg::word_t ref_mem [logic [29:0]];

    logic                       clk;
    logic                       nrst;
    logic                       rd;
    logic                       wr;
    cache_geom_pkg::addr_t      addr;
    cache_geom_pkg::word_t      wdata;
    cache_geom_pkg::word_t      rdata;
    logic                       stall;
    logic                       done;
    logic                       refill;
    logic                       update;
    logic                       l2_read;
    logic                       l2_write;
    cache_geom_pkg::line_addr_t l2_addr;
    cache_geom_pkg::line_t      l2_wline;
    logic                       l2_ready;
    cache_geom_pkg::line_t      l2_rline;
    int                         l2_errors;
    int                         checks;
    int                         errors;

    l1_cache_top u_l1_cache_top (
        .clk      (clk),
        .nrst     (nrst),
        .rd       (rd),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .rdata    (rdata),
        .stall    (stall),
        .done     (done),
        .refill   (refill),
        .update   (update),
        .l2_read  (l2_read),
        .l2_write (l2_write),
        .l2_addr  (l2_addr),
        .l2_wline (l2_wline),
        .l2_ready (l2_ready),
        .l2_rline (l2_rline)
    );

    l2_mem_model #(
        .seed_init (SEED)
    ) u_l2 (
        .clk             (clk),
        .nrst            (nrst),
        .l2_read         (l2_read),
        .l2_write        (l2_write),
        .l2_addr         (l2_addr),
        .l2_wline        (l2_wline),
        .l2_ready        (l2_ready),
        .l2_rline        (l2_rline),
        .protocol_errors (l2_errors)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[ERROR] %0d ns: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // word memory as the processor sees it
    function automatic cache_geom_pkg::word_t ref_read(input cache_geom_pkg::addr_t a);
        if (ref_mem.exists(a[31:2]))
            return ref_mem[a[31:2]];
        return {2'b00, a[31:2]};
    endfunction

    task automatic set_access(input int i, input logic op_wr, input cache_geom_pkg::addr_t a,
                              input cache_geom_pkg::word_t d, input logic hit, input logic wb,
                              input cache_geom_pkg::addr_t victim);
        tests[i].wr     = op_wr;
        tests[i].addr   = a;
        tests[i].wdata  = d;
        tests[i].hit    = hit;
        tests[i].wb     = wb;
        tests[i].victim = victim;
    endtask

    task automatic load_table();
        // index, write, address, write data, hit, write back, victim
        set_access(0,  1'b0, 32'h0000_1040, 32'h0,         1'b0, 1'b0, 32'h0);
        set_access(1,  1'b0, 32'h0000_1048, 32'h0,         1'b1, 1'b0, 32'h0);
        set_access(2,  1'b1, 32'h0000_1044, 32'hdeadbeef,  1'b1, 1'b0, 32'h0);
        set_access(3,  1'b0, 32'h0000_1044, 32'h0,         1'b1, 1'b0, 32'h0);
        set_access(4,  1'b1, 32'h0000_2080, 32'hcafef00d,  1'b0, 1'b0, 32'h0);
        set_access(5,  1'b0, 32'h0000_2080, 32'h0,         1'b1, 1'b0, 32'h0);
        set_access(6,  1'b0, 32'h0000_3080, 32'h0,         1'b0, 1'b1, 32'h0000_2080);
        set_access(7,  1'b0, 32'h0000_2084, 32'h0,         1'b0, 1'b0, 32'h0);
        set_access(8,  1'b0, 32'h0000_2080, 32'h0,         1'b1, 1'b0, 32'h0);
        set_access(9,  1'b1, 32'h0000_1050, 32'h12345678,  1'b1, 1'b0, 32'h0);
        set_access(10, 1'b1, 32'h0005_5040, 32'h0badf00d,  1'b0, 1'b1, 32'h0000_1040);
        set_access(11, 1'b0, 32'h0000_1050, 32'h0,         1'b0, 1'b1, 32'h0005_5040);
        set_access(12, 1'b0, 32'h0005_5040, 32'h0,         1'b0, 1'b0, 32'h0);
        set_access(13, 1'b0, 32'hffff_ffc0, 32'h0,         1'b0, 1'b0, 32'h0);
        set_access(14, 1'b1, 32'hffff_fffc, 32'ha5a5a5a5,  1'b1, 1'b0, 32'h0);
        set_access(15, 1'b0, 32'hffff_fffc, 32'h0,         1'b1, 1'b0, 32'h0);
        set_access(16, 1'b0, 32'h0000_0000, 32'h0,         1'b0, 1'b0, 32'h0);
        set_access(17, 1'b0, 32'h0000_003c, 32'h0,         1'b1, 1'b0, 32'h0);
    endtask

    // one access, driven from a falling edge until done
    task automatic run_access(input int i);
        access_t                    t;
        int                         cycles;
        int                         refills;
        int                         updates;
        logic                       got_done;
        logic                       saw_read;
        logic                       saw_write;
        logic                       write_first;
        cache_geom_pkg::line_addr_t read_addr;
        cache_geom_pkg::line_addr_t wb_addr;
        cache_geom_pkg::line_t      wb_line;
        cache_geom_pkg::word_t      got_data;

        t           = tests[i];
        cycles      = 0;
        refills     = 0;
        updates     = 0;
        got_done    = 1'b0;
        saw_read    = 1'b0;
        saw_write   = 1'b0;
        write_first = 1'b0;
        rd          = !t.wr;
        wr          = t.wr;
        addr        = t.addr;
        wdata       = t.wdata;
        while (!got_done && cycles < ACCESS_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            if (l2_write && !saw_write)
            begin
                saw_write = 1'b1;
                wb_addr   = l2_addr;
                wb_line   = l2_wline;
            end
            if (l2_read && !saw_read)
            begin
                saw_read    = 1'b1;
                read_addr   = l2_addr;
                write_first = saw_write;
            end
            refills += refill;
            updates += update;
            if (done)
            begin
                got_done = 1'b1;
                got_data = rdata;
            end
            else
                check_eq("stall", stall, 1'b1);
        end
        rd = 1'b0;
        wr = 1'b0;
        if (!got_done)
        begin
            errors++;
            $display("access %0d to address %h did not complete", i, t.addr);
        end
        else
        begin
            if (t.hit)
                check_eq("done latency", cycles, 2);
            check_eq("l2_read", saw_read, !t.hit);
            check_eq("l2_write", saw_write, t.wb);
            check_eq("refill", refills, !t.hit && !t.wr);
            check_eq("update", updates, !t.hit && t.wr);
            if (saw_read)
                check_eq("l2_addr on read", read_addr, t.addr[31:6]);
            if (saw_write && t.wb)
            begin
                check_eq("l2_addr on write back", wb_addr, t.victim[31:6]);
                check_eq("write back before read", write_first, 1'b1);
                for (int w = 0; w < 16; w++)
                    check_eq("l2_wline", wb_line[w*32 +: 32],
                             ref_read({t.victim[31:6], 4'(w), 2'b00}));
            end
            if (t.wr)
                ref_mem[t.addr[31:2]] = t.wdata;
            else
                check_eq("rdata", got_data, ref_read(t.addr));
        end
        // done and stall low again in the idle cycle before the next request
        @(negedge clk);
        if (got_done)
        begin
            check_eq("done", done, 1'b0);
            check_eq("stall", stall, 1'b0);
        end
    endtask

    initial
    begin
        clk    = 1'b0;
        nrst   = 1'b0;
        rd     = 1'b0;
        wr     = 1'b0;
        addr   = '0;
        wdata  = '0;
        checks = 0;
        errors = 0;
        load_table();
        repeat (4) @(negedge clk);
        check_eq("stall", stall, 1'b0);
        check_eq("done", done, 1'b0);
        check_eq("refill", refill, 1'b0);
        check_eq("update", update, 1'b0);
        check_eq("l2_read", l2_read, 1'b0);
        check_eq("l2_write", l2_write, 1'b0);
        nrst = 1'b1;
        @(negedge clk);
        for (int i = 0; i < NUM_ACCESSES; i++)
            run_access(i);
        $display("%0d checks, %0d errors, %0d of them on the l2 side",
                 checks, errors + l2_errors, l2_errors);
        if (errors + l2_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // generous bound per access on top of reset
    initial
    begin
        #((NUM_ACCESSES * ACCESS_LIMIT + 10) * CLK_PERIOD);
        $display("watchdog expired before the last access finished");
        $display("%0d checks, %0d errors", checks, errors + l2_errors + 1);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/l2_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model #(
    parameter logic [31:0] seed_init = 32'h29fc97c7
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       l2_read,
    input  logic                       l2_write,
    input  cache_geom_pkg::line_addr_t l2_addr,
    input  cache_geom_pkg::line_t      l2_wline,
    output logic                       l2_ready,
    output cache_geom_pkg::line_t      l2_rline,
    output int                         protocol_errors
);

    // only lines that were written back are stored
    cache_geom_pkg::line_t lines [cache_geom_pkg::line_addr_t];

    integer                     seed;
    logic                       pending;
    logic                       req_write;
    cache_geom_pkg::line_addr_t req_addr;
    int                         wait_cnt;

    // each word holds its own word address
    function automatic cache_geom_pkg::line_t pattern_line(
        input cache_geom_pkg::line_addr_t la
    );
        cache_geom_pkg::line_t line;
        for (int w = 0; w < 16; w++)
            line[w*32 +: 32] = {2'b00, la, 4'(w)};
        return line;
    endfunction

    initial
    begin
        seed            = seed_init;
        l2_ready        = 1'b0;
        l2_rline        = '0;
        pending         = 1'b0;
        req_write       = 1'b0;
        req_addr        = '0;
        wait_cnt        = 0;
        protocol_errors = 0;
    end

    always @(negedge clk)
    begin
        if (!nrst)
        begin
            l2_ready = 1'b0;
            pending  = 1'b0;
        end
        else if (l2_ready)
        begin
            // taken on the rising edge just passed
            l2_ready = 1'b0;
            pending  = 1'b0;
        end
        else if (pending)
        begin
            assert (l2_read === !req_write && l2_write === req_write && l2_addr === req_addr)
            else
            begin
                protocol_errors++;
                $display("[ERROR] %0d ns: l2 request got rd %b wr %b addr %h, expected %b %b %h",
                         $time, l2_read, l2_write, l2_addr, !req_write, req_write, req_addr);
            end
            if (wait_cnt > 0)
                wait_cnt--;
        end
        else if (l2_read || l2_write)
        begin
            pending   = 1'b1;
            req_write = l2_write;
            req_addr  = l2_addr;
            wait_cnt  = {$random(seed)} % 6;
        end
        if (pending && !l2_ready && wait_cnt == 0)
        begin
            if (req_write)
                lines[req_addr] = l2_wline;
            else if (lines.exists(req_addr))
                l2_rline = lines[req_addr];
            else
                l2_rline = pattern_line(req_addr);
            l2_ready = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/l1_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_cache_top #(
    parameter int num_lines = cache_geom_pkg::NUM_LINES
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       rd,
    input  logic                       wr,
    input  cache_geom_pkg::addr_t      addr,
    input  cache_geom_pkg::word_t      wdata,
    output cache_geom_pkg::word_t      rdata,
    output logic                       stall,
    output logic                       done,
    output logic                       refill,
    output logic                       update,
    output logic                       l2_read,
    output logic                       l2_write,
    output cache_geom_pkg::line_addr_t l2_addr,
    output cache_geom_pkg::line_t      l2_wline,
    input  logic                       l2_ready,
    input  cache_geom_pkg::line_t      l2_rline
);

    localparam int OFFSET_LSB = cache_geom_pkg::BYTE_W;
    localparam int INDEX_LSB  = OFFSET_LSB + cache_geom_pkg::OFFSET_W;

    cache_geom_pkg::tag_t    tag;
    cache_geom_pkg::index_t  index;
    cache_geom_pkg::offset_t offset;

    logic fill_en;
    logic wr_en;

    // tag | index | word offset | byte offset
    assign tag    = addr[cache_geom_pkg::ADDR_W-1 -: cache_geom_pkg::TAG_W];
    assign index  = addr[INDEX_LSB +: cache_geom_pkg::INDEX_W];
    assign offset = addr[OFFSET_LSB +: cache_geom_pkg::OFFSET_W];

    l1_controller #(
        .num_lines (num_lines)
    ) u_ctrl (
        .clk      (clk),
        .nrst     (nrst),
        .rd       (rd),
        .wr       (wr),
        .tag      (tag),
        .index    (index),
        .l2_ready (l2_ready),
        .stall    (stall),
        .done     (done),
        .refill   (refill),
        .update   (update),
        .l2_read  (l2_read),
        .l2_write (l2_write),
        .l2_addr  (l2_addr),
        .fill_en  (fill_en),
        .wr_en    (wr_en)
    );

    l1_data_array #(
        .num_lines (num_lines)
    ) u_data (
        .clk         (clk),
        .nrst        (nrst),
        .index       (index),
        .offset      (offset),
        .wdata       (wdata),
        .wr_en       (wr_en),
        .fill_en     (fill_en),
        .l2_rline    (l2_rline),
        .done        (done),
        .rd_word     (rdata),
        .victim_line (l2_wline)
    );

endmodule

`default_nettype wire

// ==== hdl/l1_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_data_array #(
    parameter int num_lines = cache_geom_pkg::NUM_LINES
) (
    input  logic                    clk,
    input  logic                    nrst,
    input  cache_geom_pkg::index_t  index,
    input  cache_geom_pkg::offset_t offset,
    input  cache_geom_pkg::word_t   wdata,
    input  logic                    wr_en,
    input  logic                    fill_en,
    input  cache_geom_pkg::line_t   l2_rline,
    input  logic                    done,
    output cache_geom_pkg::word_t   rd_word,
    output cache_geom_pkg::line_t   victim_line
);

    localparam int WORDS  = cache_geom_pkg::WORDS_PER_LINE;
    localparam int WORD_W = cache_geom_pkg::WORD_W;

    // num_lines lines of WORDS words each
    cache_geom_pkg::word_t mem [num_lines][WORDS];

    cache_geom_pkg::word_t addr_word;

    assign addr_word = mem[index][offset];

    // whole-line fill from the next level has priority
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            for (int w = 0; w < WORDS; w++)
                mem[index][w] <= l2_rline[w*WORD_W +: WORD_W];
        end
        else if (wr_en)
            mem[index][offset] <= wdata;
    end

    // follows the addressed word, frozen while done is high
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
            rd_word <= '0;
        else if (!done)
            rd_word <= addr_word;
    end

    // line at index, drained to the next level on write back
    always_comb
    begin
        for (int w = 0; w < WORDS; w++)
            victim_line[w*WORD_W +: WORD_W] = mem[index][w];
    end

endmodule

`default_nettype wire

// ==== hdl/l1_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_controller #(
    parameter int num_lines = cache_geom_pkg::NUM_LINES
) (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       rd,
    input  logic                       wr,
    input  cache_geom_pkg::tag_t       tag,
    input  cache_geom_pkg::index_t     index,
    input  logic                       l2_ready,
    output logic                       stall,
    output logic                       done,
    output logic                       refill,
    output logic                       update,
    output logic                       l2_read,
    output logic                       l2_write,
    output cache_geom_pkg::line_addr_t l2_addr,
    output logic                       fill_en,
    output logic                       wr_en
);

    cache_geom_pkg::tag_t tag_arr [num_lines];
    logic [num_lines-1:0] valid;
    logic [num_lines-1:0] dirty;

    cache_fsm_pkg::ctrl_state_e state;
    cache_fsm_pkg::ctrl_state_e next_state;
    cache_fsm_pkg::l2_req_e     l2_req;
    cache_fsm_pkg::l2_req_e     next_req;

    logic hit;
    logic victim_dirty;
    logic line_fill;
    logic victim_sent;

    assign hit          = valid[index] && (tag_arr[index] == tag);
    assign victim_dirty = valid[index] && dirty[index];

    // next level answered the current request
    assign line_fill   = (state == cache_fsm_pkg::st_allocate) && l2_ready;
    assign victim_sent = (state == cache_fsm_pkg::st_write_back) && l2_ready;

    assign stall   = (state != cache_fsm_pkg::st_idle);
    assign fill_en = line_fill;
    assign wr_en   = (state == cache_fsm_pkg::st_compare) && hit && wr;

    assign l2_read  = (l2_req == cache_fsm_pkg::req_read);
    assign l2_write = (l2_req == cache_fsm_pkg::req_write);

    always_comb
    begin
        next_state = state;
        case (state)
            cache_fsm_pkg::st_idle:
            begin
                // the done cycle still sees the finished request
                if ((rd || wr) && !done)
                    next_state = cache_fsm_pkg::st_compare;
            end
            cache_fsm_pkg::st_compare:
            begin
                if (hit)
                    next_state = cache_fsm_pkg::st_idle;
                else if (victim_dirty)
                    next_state = cache_fsm_pkg::st_write_back;
                else
                    next_state = cache_fsm_pkg::st_allocate;
            end
            cache_fsm_pkg::st_write_back:
            begin
                if (l2_ready)
                    next_state = cache_fsm_pkg::st_allocate;
            end
            cache_fsm_pkg::st_allocate:
            begin
                if (l2_ready)
                    next_state = cache_fsm_pkg::st_compare;
            end
            default:
                next_state = cache_fsm_pkg::st_idle;
        endcase
    end

    always_comb
    begin
        case (next_state)
            cache_fsm_pkg::st_write_back:
                next_req = cache_fsm_pkg::req_write;
            cache_fsm_pkg::st_allocate:
                next_req = cache_fsm_pkg::req_read;
            default:
                next_req = cache_fsm_pkg::req_none;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state  <= cache_fsm_pkg::st_idle;
            l2_req <= cache_fsm_pkg::req_none;
        end
        else
        begin
            state  <= next_state;
            l2_req <= next_req;
        end
    end

    // single-cycle pulses toward the processor
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            done   <= 1'b0;
            refill <= 1'b0;
            update <= 1'b0;
        end
        else
        begin
            done   <= (state == cache_fsm_pkg::st_compare) && hit;
            refill <= line_fill && rd;
            update <= line_fill && wr;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else if (line_fill)
        begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;
        end
        else if (victim_sent)
            dirty[index] <= 1'b0;
        else if (wr_en)
            dirty[index] <= 1'b1;
    end

    // tag of the line filled at index
    always_ff @(posedge clk)
    begin
        if (line_fill)
            tag_arr[index] <= tag;
    end

    // victim line during write back and missing line otherwise
    always_comb
    begin
        if (state == cache_fsm_pkg::st_write_back)
            l2_addr = {tag_arr[index], index};
        else
            l2_addr = {tag, index};
    end

endmodule

`default_nettype wire

// ==== hdl/cache_fsm_pkg.sv ====
`default_nettype none

package cache_fsm_pkg;

    // miss handling states of the controller
    typedef enum logic [1:0] {
        st_idle       = 2'b00,
        st_compare    = 2'b01,
        st_write_back = 2'b10,
        st_allocate   = 2'b11
    } ctrl_state_e;

    // level presented to the next level
    typedef enum logic [1:0] {
        req_none  = 2'b00,
        req_read  = 2'b01,
        req_write = 2'b10
    } l2_req_e;

endpackage

`default_nettype wire

// ==== hdl/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    localparam int ADDR_W         = 32;
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 6;
    localparam int OFFSET_W       = 4;
    // byte offset within a word, ignored by the cache
    localparam int BYTE_W         = 2;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
    localparam int NUM_LINES      = 1 << INDEX_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [LINE_W-1:0]   line_t;

    // tag and index, the line address seen by the next level
    typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;

endpackage

`default_nettype wire
